/* project.f */
+incdir+include
src/rw_gen_pkg.sv
src/rw_gen_control.sv
src/rw_address_stage.sv
src/rw_pending_queue.sv
src/rw_response_merge.sv
src/rw_gen_top.sv
test/rw_gen_tb.sv

/* test/rw_gen_tb.sv */
/*
  Testbench for the request generator. Inputs change on the falling edge
  and outputs are sampled there. The memory model answers in order after
  1 to 6 cycles, so outstanding requests stay well below the queue depth.
*/

`timescale 1ns/1ps

`include "rw_gen_consts.svh"

module rw_gen_tb;

    import rw_gen_pkg::*;

    localparam int READ_ITEMS   = 10;
    localparam int WRITE_ITEMS  = 8;
    localparam int CYCLE_LIMIT  = (READ_ITEMS + WRITE_ITEMS) * 12 + 200;
    localparam int RESET_CYCLES = 8;
    localparam int IDLE_STROBES = 6;
    localparam logic [`RW_DATA_W-1:0] MEM_XOR = 32'h5a5a_c3c3;

    logic             ap_clk;
    logic             areset_generator;
    logic             cfg_valid;
    rw_config_t       cfg;
    logic             engine_valid;
    engine_packet_t   engine_in;
    logic             mem_rsp_valid;
    mem_response_t    mem_rsp;
    logic             mem_req_valid;
    mem_request_t     mem_req;
    logic             engine_rsp_valid;
    engine_response_t engine_rsp;
    logic             busy;
    logic             done;

    integer seed       = 32'ha7bf;
    int     cycle      = 0;
    int     done_count = 0;
    logic   busy_prev  = 1'b0;
    string  test_name  = "reset";

    // Expectations in issue order, with the cycle each strobe is due
    mem_request_t          exp_req_q[$];
    engine_response_t      exp_rsp_q[$];
    int                    req_cycle_q[$];
    int                    rsp_cycle_q[$];
    int                    due_q[$];
    logic [`RW_DATA_W-1:0] mem_data_q[$];

    rw_gen_top dut_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg              (cfg),
        .engine_valid     (engine_valid),
        .engine_in        (engine_in),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp          (mem_rsp),
        .mem_req_valid    (mem_req_valid),
        .mem_req          (mem_req),
        .engine_rsp_valid (engine_rsp_valid),
        .engine_rsp       (engine_rsp),
        .busy             (busy),
        .done             (done)
    );

    initial begin
        ap_clk = 1'b0;
        forever #2 ap_clk = ~ap_clk;
    end

    // ------------------------------
    // Error reporting
    // ------------------------------
    task automatic stop_run();
        $display("=== FAIL ===");
        $fatal(1, "Stopping after the first error");
    endtask

    task automatic report_error(input string msg);
        $display("ERROR: %s", msg);
        stop_run();
    endtask

    task automatic check_mem_req(input string name, input mem_request_t exp,
                                 input mem_request_t act);
        if (act !== exp) begin
            $write("FAIL %s mem_req expected op=%0d addr=%h data=%h seq=%h",
                   name, exp.opcode, exp.address, exp.data, exp.seq_id);
            $display(" actual op=%0d addr=%h data=%h seq=%h",
                     act.opcode, act.address, act.data, act.seq_id);
            stop_run();
        end
    endtask

    task automatic check_engine_rsp(input string name, input engine_response_t exp,
                                    input engine_response_t act);
        if (act !== exp) begin
            $display("FAIL %s engine_rsp expected seq=%h data=%h actual seq=%h data=%h",
                     name, exp.seq_id, exp.data, act.seq_id, act.data);
            stop_run();
        end
    endtask

    task automatic check_done(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s done pulses expected %0d actual %0d", name, exp, act);
            stop_run();
        end
    endtask

    task automatic check_level(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("FAIL %s expected %b actual %b", name, exp, act);
            stop_run();
        end
    endtask

    task automatic verify_latency(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("FAIL %s expected cycle %0d actual cycle %0d", name, exp, act);
            stop_run();
        end
    endtask

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [`RW_DATA_W-1:0] memory_word(input logic [`RW_ADDR_W-1:0] addr);
        return addr ^ MEM_XOR;
    endfunction

    function automatic mem_request_t expected_request(input rw_config_t job,
                                                      input engine_packet_t pkt);
        mem_request_t          req;
        logic [`RW_ADDR_W-1:0] offset;
        offset      = pkt.index;
        offset      = offset << job.word_shift;
        req.opcode  = job.opcode;
        req.address = job.base_addr + offset;
        req.data    = pkt.data;
        req.seq_id  = pkt.seq_id;
        return req;
    endfunction

    function automatic engine_response_t expected_response(input mem_request_t req);
        engine_response_t rsp;
        rsp.seq_id = req.seq_id;
        rsp.data   = (req.opcode == RW_OP_READ) ? memory_word(req.address) : req.data;
        return rsp;
    endfunction

    function automatic engine_packet_t random_packet();
        engine_packet_t pkt;
        pkt.seq_id = $random(seed);
        pkt.index  = $random(seed);
        pkt.data   = $random(seed);
        return pkt;
    endfunction

    // Cycle count and run limit
    initial begin
        while (cycle < CYCLE_LIMIT) begin
            @(posedge ap_clk);
            cycle = cycle + 1;
        end
        report_error($sformatf("Run did not finish within %0d cycles", CYCLE_LIMIT));
    end

    // In-order memory, one response per cycle at most
    initial begin
        int due;
        int last_due;
        last_due      = 0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        // Stray responses before any job find the queue empty
        repeat (RESET_CYCLES) @(negedge ap_clk);
        repeat (IDLE_STROBES) begin
            mem_rsp_valid = 1'b1;
            mem_rsp.data  = $random(seed);
            @(negedge ap_clk);
        end
        mem_rsp_valid = 1'b0;
        forever begin
            @(negedge ap_clk);
            if (mem_req_valid) begin
                due = cycle + 1 + ($unsigned($random(seed)) % 6);
                if (due <= last_due) begin
                    due = last_due + 1;
                end
                last_due = due;
                due_q.push_back(due);
                if (mem_req.opcode == RW_OP_READ) begin
                    mem_data_q.push_back(memory_word(mem_req.address));
                end else begin
                    mem_data_q.push_back($random(seed));
                end
            end
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                void'(due_q.pop_front());
                mem_rsp_valid = 1'b1;
                mem_rsp.data  = mem_data_q.pop_front();
                rsp_cycle_q.push_back(cycle + 1);
            end else begin
                mem_rsp_valid = 1'b0;
            end
        end
    end

    // ------------------------------
    // Monitor
    // ------------------------------
    initial begin
        forever begin
            @(negedge ap_clk);
            if (mem_req_valid) begin
                if (exp_req_q.size() == 0) begin
                    report_error({"Memory request without an accepted item in ", test_name});
                end else begin
                    verify_latency({test_name, " mem_req"}, req_cycle_q.pop_front(), cycle);
                    check_mem_req(test_name, exp_req_q.pop_front(), mem_req);
                end
            end else if (req_cycle_q.size() != 0 && req_cycle_q[0] <= cycle) begin
                report_error({"Accepted item produced no memory request in ", test_name});
            end
            if (engine_rsp_valid) begin
                if (exp_rsp_q.size() == 0 || rsp_cycle_q.size() == 0) begin
                    report_error({"Engine response without a memory response in ", test_name});
                end else begin
                    verify_latency({test_name, " engine_rsp"}, rsp_cycle_q.pop_front(), cycle);
                    check_engine_rsp(test_name, exp_rsp_q.pop_front(), engine_rsp);
                end
            end else if (rsp_cycle_q.size() != 0 && rsp_cycle_q[0] <= cycle) begin
                report_error({"Memory response produced no engine response in ", test_name});
            end
            if (done) begin
                done_count = done_count + 1;
                check_level({test_name, " busy during done"}, 1'b0, busy);
                check_level({test_name, " busy before done"}, 1'b1, busy_prev);
                if (exp_rsp_q.size() != 0) begin
                    report_error({"Done raised with responses still pending in ", test_name});
                end
            end
            busy_prev = busy;
        end
    end

    // Loads one job, sends its items plus extra strobes, waits for done
    task automatic run_job(input string name, input rw_opcode_e op,
                           input logic [`RW_ADDR_W-1:0] base,
                           input logic [`RW_SHIFT_W-1:0] shift,
                           input int count, input int extra);
        rw_config_t     job;
        engine_packet_t pkt;
        mem_request_t   req;
        int             pulses_before;
        test_name      = name;
        pulses_before  = done_count;
        job.opcode     = op;
        job.base_addr  = base;
        job.word_shift = shift;
        job.item_count = count;
        cfg            = job;
        cfg_valid      = 1'b1;
        @(negedge ap_clk);
        cfg_valid = 1'b0;
        check_level({name, " busy after config"}, 1'b1, busy);
        for (int i = 0; i < count + extra; i++) begin
            pkt          = random_packet();
            engine_in    = pkt;
            engine_valid = 1'b1;
            if (i < count) begin
                req = expected_request(job, pkt);
                exp_req_q.push_back(req);
                exp_rsp_q.push_back(expected_response(req));
                req_cycle_q.push_back(cycle + 1);
            end
            @(negedge ap_clk);
            engine_valid = 1'b0;
            if ($random(seed) % 4 == 0) begin
                @(negedge ap_clk);
            end
        end
        while (done_count == pulses_before) begin
            @(negedge ap_clk);
        end
        // A second pulse would show up here
        repeat (4) @(negedge ap_clk);
        check_done(name, pulses_before + 1, done_count);
    endtask

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        areset_generator = 1'b1;
        cfg_valid        = 1'b0;
        cfg              = '0;
        engine_valid     = 1'b0;
        engine_in        = '0;
        repeat (RESET_CYCLES) @(negedge ap_clk);
        areset_generator = 1'b0;
        // Engine strobes and memory responses before any job must be ignored
        repeat (IDLE_STROBES) begin
            engine_valid = 1'b1;
            engine_in    = random_packet();
            @(negedge ap_clk);
            check_level("reset busy", 1'b0, busy);
            check_level("reset done", 1'b0, done);
            check_level("reset mem_req_valid", 1'b0, mem_req_valid);
            check_level("reset engine_rsp_valid", 1'b0, engine_rsp_valid);
        end
        engine_valid = 1'b0;
        run_job("read_job", RW_OP_READ, 32'h1000_0000, 3'd2, READ_ITEMS, 3);
        run_job("write_job", RW_OP_WRITE, 32'h2000_0040, 3'd3, WRITE_ITEMS, 2);
        run_job("zero_job", RW_OP_READ, 32'h3000_0000, 3'd2, 0, 2);
        $display("=== PASS ===");
        $finish;
    end

endmodule

/* src/rw_gen_top.sv */
/*
  Memory read/write request generator for one engine.
  All transfers are single-cycle valid strobes with no back-pressure.
  Outstanding requests must stay within the pending queue depth.
*/

`timescale 1ns/1ps

module rw_gen_top (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         cfg_valid,
    input  rw_gen_pkg::rw_config_t       cfg,
    input  logic                         engine_valid,
    input  rw_gen_pkg::engine_packet_t   engine_in,
    input  logic                         mem_rsp_valid,
    input  rw_gen_pkg::mem_response_t    mem_rsp,
    output logic                         mem_req_valid,
    output rw_gen_pkg::mem_request_t     mem_req,
    output logic                         engine_rsp_valid,
    output rw_gen_pkg::engine_response_t engine_rsp,
    output logic                         busy,
    output logic                         done
);

    import rw_gen_pkg::*;

    rw_config_t   job;
    logic         accept;
    logic         pop;
    logic         empty;
    mem_request_t head;

    rw_gen_control control_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .cfg_valid        (cfg_valid),
        .cfg              (cfg),
        .engine_valid     (engine_valid),
        .mem_req_valid    (mem_req_valid),
        .engine_rsp_valid (engine_rsp_valid),
        .job              (job),
        .accept           (accept),
        .busy             (busy),
        .done             (done)
    );

    // ------------------------------
    // Request pipeline
    // ------------------------------
    rw_address_stage address_stage_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .accept           (accept),
        .engine_valid     (engine_valid),
        .engine_in        (engine_in),
        .job              (job),
        .mem_req_valid    (mem_req_valid),
        .mem_req          (mem_req)
    );

    rw_pending_queue pending_queue_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (mem_req_valid),
        .push_entry       (mem_req),
        .pop              (pop),
        .head             (head),
        .empty            (empty)
    );

    rw_response_merge response_merge_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .mem_rsp_valid    (mem_rsp_valid),
        .mem_rsp          (mem_rsp),
        .head             (head),
        .empty            (empty),
        .pop              (pop),
        .engine_rsp_valid (engine_rsp_valid),
        .engine_rsp       (engine_rsp)
    );

endmodule

/* src/rw_response_merge.sv */
/*
  Pairs each memory response with the oldest pending request.
  Responses are assumed to come back in issue order. A response that finds
  the queue empty is dropped.
*/

`timescale 1ns/1ps

module rw_response_merge (
    input  logic                         ap_clk,
    input  logic                         areset_generator,
    input  logic                         mem_rsp_valid,
    input  rw_gen_pkg::mem_response_t    mem_rsp,
    input  rw_gen_pkg::mem_request_t     head,
    input  logic                         empty,
    output logic                         pop,
    output logic                         engine_rsp_valid,
    output rw_gen_pkg::engine_response_t engine_rsp
);

    import rw_gen_pkg::*;

    assign pop = mem_rsp_valid && !empty;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            engine_rsp_valid <= 1'b0;
        end else begin
            engine_rsp_valid <= pop;
        end
    end

    // Reads return memory data, writes echo what was written
    always_ff @(posedge ap_clk) begin
        if (pop) begin
            engine_rsp.seq_id <= head.seq_id;
            engine_rsp.data   <= (head.opcode == RW_OP_READ) ? mem_rsp.data : head.data;
        end
    end

endmodule

/* src/rw_pending_queue.sv */
/*
  In-order queue of issued requests waiting for a memory response.
  Head shows the oldest entry in the same cycle. There is no full flag:
  a push into a full queue overwrites the oldest entry. Pop on empty is ignored.
*/

`timescale 1ns/1ps

`include "rw_gen_consts.svh"

module rw_pending_queue (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  logic                     push,
    input  rw_gen_pkg::mem_request_t push_entry,
    input  logic                     pop,
    output rw_gen_pkg::mem_request_t head,
    output logic                     empty
);

    import rw_gen_pkg::*;

    localparam int PTR_W = $clog2(`RW_QUEUE_DEPTH);

    mem_request_t     entries [`RW_QUEUE_DEPTH];
    logic [PTR_W:0]   wr_ptr;
    logic [PTR_W:0]   rd_ptr;
    logic             do_pop;

    // Extra pointer bit tells full from empty on wrap
    assign empty  = (wr_ptr == rd_ptr);
    assign do_pop = pop && !empty;
    assign head   = entries[rd_ptr[PTR_W-1:0]];

    // ------------------------------
    // Pointers
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Storage
    always_ff @(posedge ap_clk) begin
        if (push) begin
            entries[wr_ptr[PTR_W-1:0]] <= push_entry;
        end
    end

endmodule

/* src/rw_address_stage.sv */
/*
  Address stage of the request pipeline.
  One accepted engine packet gives one memory request on the next cycle.
  The index is zero extended before the shift, and the address sum wraps.
*/

`timescale 1ns/1ps

`include "rw_gen_consts.svh"

module rw_address_stage (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       accept,
    input  logic                       engine_valid,
    input  rw_gen_pkg::engine_packet_t engine_in,
    input  rw_gen_pkg::rw_config_t     job,
    output logic                       mem_req_valid,
    output rw_gen_pkg::mem_request_t   mem_req
);

    logic                  take_item;
    logic [`RW_ADDR_W-1:0] index_ext;
    logic [`RW_ADDR_W-1:0] offset;

    assign take_item = engine_valid && accept;

    // Byte offset of the item from the job base
    assign index_ext = {{(`RW_ADDR_W - `RW_INDEX_W){1'b0}}, engine_in.index};
    assign offset    = index_ext << job.word_shift;

    // ------------------------------
    // Request register
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            mem_req_valid <= 1'b0;
        end else begin
            mem_req_valid <= take_item;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (take_item) begin
            mem_req.opcode  <= job.opcode;
            mem_req.address <= job.base_addr + offset;
            mem_req.data    <= engine_in.data;
            mem_req.seq_id  <= engine_in.seq_id;
        end
    end

endmodule

/* src/rw_gen_control.sv */
/*
  Job control for the request generator.
  A configuration is taken only in idle. Done is a one-cycle strobe and busy
  drops in the same cycle. Item counts up to 2**RW_COUNT_W-1 are supported.
*/

`timescale 1ns/1ps

`include "rw_gen_consts.svh"

module rw_gen_control (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  logic                   cfg_valid,
    input  rw_gen_pkg::rw_config_t cfg,
    input  logic                   engine_valid,
    input  logic                   mem_req_valid,
    input  logic                   engine_rsp_valid,
    output rw_gen_pkg::rw_config_t job,
    output logic                   accept,
    output logic                   busy,
    output logic                   done
);

    import rw_gen_pkg::*;

    rw_state_e               state;
    rw_state_e               next_state;
    logic                    load_cfg;
    logic                    take_item;
    logic                    all_accepted;
    logic                    outstanding_zero;
    logic [`RW_COUNT_W-1:0]  accepted_count;
    logic [`RW_COUNT_W-1:0]  outstanding;

    assign load_cfg         = (state == RW_IDLE) && cfg_valid;
    assign all_accepted     = (accepted_count >= job.item_count);
    assign accept           = (state == RW_BUSY) && !all_accepted;
    assign take_item        = engine_valid && accept;
    assign outstanding_zero = (outstanding == '0);

    assign busy = (state == RW_BUSY) || (state == RW_DRAIN);
    assign done = (state == RW_DONE);

    // ------------------------------
    // State machine
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= RW_IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            RW_IDLE: begin
                if (cfg_valid) begin
                    next_state = RW_BUSY;
                end
            end
            RW_BUSY: begin
                if (all_accepted) begin
                    next_state = RW_DRAIN;
                end
            end
            RW_DRAIN: begin
                // Last request must be counted before the zero check
                if (outstanding_zero && !mem_req_valid) begin
                    next_state = RW_DONE;
                end
            end
            default: begin
                next_state = RW_IDLE;
            end
        endcase
    end

    // Job held stable for the address stage until the next load
    always_ff @(posedge ap_clk) begin
        if (load_cfg) begin
            job <= cfg;
        end
    end

    // ------------------------------
    // Item and outstanding counters
    // ------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            accepted_count <= '0;
            outstanding    <= '0;
        end else begin
            if (load_cfg) begin
                accepted_count <= '0;
            end else if (take_item) begin
                accepted_count <= accepted_count + 1'b1;
            end
            if (mem_req_valid && !engine_rsp_valid) begin
                outstanding <= outstanding + 1'b1;
            end else if (!mem_req_valid && engine_rsp_valid) begin
                outstanding <= outstanding - 1'b1;
            end
        end
    end

endmodule

/* src/rw_gen_pkg.sv */
/*
  Types for the memory request generator.
  Field widths come from the constants header. All structs are packed so
  they can travel as single vectors next to their valid strobes.
*/

`include "rw_gen_consts.svh"

package rw_gen_pkg;

    typedef enum logic {
        RW_OP_READ  = 1'b0,
        RW_OP_WRITE = 1'b1
    } rw_opcode_e;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_BUSY  = 2'd1,
        RW_DRAIN = 2'd2,
        RW_DONE  = 2'd3
    } rw_state_e;

    // Job description loaded by the configuration strobe
    typedef struct packed {
        rw_opcode_e              opcode;
        logic [`RW_ADDR_W-1:0]   base_addr;
        logic [`RW_SHIFT_W-1:0]  word_shift;
        logic [`RW_COUNT_W-1:0]  item_count;
    } rw_config_t;

    typedef struct packed {
        logic [`RW_SEQ_W-1:0]   seq_id;
        logic [`RW_INDEX_W-1:0] index;
        logic [`RW_DATA_W-1:0]  data;
    } engine_packet_t;

    // Also the pending queue entry
    typedef struct packed {
        rw_opcode_e            opcode;
        logic [`RW_ADDR_W-1:0] address;
        logic [`RW_DATA_W-1:0] data;
        logic [`RW_SEQ_W-1:0]  seq_id;
    } mem_request_t;

    typedef struct packed {
        logic [`RW_DATA_W-1:0] data;
    } mem_response_t;

    typedef struct packed {
        logic [`RW_SEQ_W-1:0]  seq_id;
        logic [`RW_DATA_W-1:0] data;
    } engine_response_t;

endpackage

/* include/rw_gen_consts.svh */
/*
  Widths and depths shared by the request generator RTL and its testbench.
  The pending queue depth must be a power of two. Senders keep the number
  of outstanding requests at or below it, since the queue has no overflow guard.
*/

`ifndef RW_GEN_CONSTS_SVH
`define RW_GEN_CONSTS_SVH

// Data and address paths
`define RW_DATA_W 32
`define RW_ADDR_W 32

// Engine packet fields
`define RW_INDEX_W 16
`define RW_SEQ_W 8

// Item count and outstanding counter
`define RW_COUNT_W 16

// Word shift applied to the index, 0 to 7
`define RW_SHIFT_W 3

// Pending queue entries
`define RW_QUEUE_DEPTH 16

`endif
